// File: hw/core_pkg.sv
package core_pkg;

    localparam int WORD_BITS = 32;
    localparam int ADDR_BITS = 16;
    localparam int REG_ADDR_BITS = 5;

    typedef logic [WORD_BITS-1:0] word_t;
    // low bits of the PC or of an ALU result
    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [3:0] alu_op_t;

    localparam alu_op_t ALU_OP_NONE = 4'd0;
    localparam alu_op_t ALU_OP_ADD = 4'd1;
    localparam alu_op_t ALU_OP_SUB = 4'd2;
    localparam alu_op_t ALU_OP_SLL = 4'd3;
    localparam alu_op_t ALU_OP_SLT = 4'd4;
    localparam alu_op_t ALU_OP_SLTU = 4'd5;
    localparam alu_op_t ALU_OP_XOR = 4'd6;
    localparam alu_op_t ALU_OP_SRL = 4'd7;
    localparam alu_op_t ALU_OP_SRA = 4'd8;
    localparam alu_op_t ALU_OP_OR = 4'd9;
    localparam alu_op_t ALU_OP_AND = 4'd10;

    // RV32I major opcodes, inst[6:0]
    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL = 7'b1101111;
    localparam logic [6:0] OPC_JALR = 7'b1100111;
    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_ALU_IMM = 7'b0010011;
    localparam logic [6:0] OPC_ALU_REG = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam word_t INST_BYTES = 32'd4;

    typedef enum logic [3:0] {
        ST_INIT,
        ST_FETCH,
        ST_FETCH_WAIT,
        ST_DECODE,
        ST_READ_REGS,
        ST_EXECUTE,
        ST_LOAD,
        ST_LOAD_WAIT,
        ST_STORE,
        ST_RETIRE,
        ST_HALTED
    } seq_state_t;

endpackage

// File: hw/alu.sv
`timescale 1ns/1ps

module alu (
    input logic clock,
    input core_pkg::word_t operand1,
    input core_pkg::word_t operand2,
    input core_pkg::alu_op_t operator,
    output core_pkg::word_t result
);
    import core_pkg::*;

    logic less_signed;
    logic less_unsigned;

    assign less_signed = $signed(operand1) < $signed(operand2);
    assign less_unsigned = operand1 < operand2;

    always_ff @(posedge clock) begin
        case (operator)
            ALU_OP_ADD: result <= operand1 + operand2;
            ALU_OP_SUB: result <= operand1 - operand2;
            ALU_OP_SLL: result <= operand1 << operand2[4:0];
            ALU_OP_SLT: result <= {{(WORD_BITS-1){1'b0}}, less_signed};
            ALU_OP_SLTU: result <= {{(WORD_BITS-1){1'b0}}, less_unsigned};
            ALU_OP_XOR: result <= operand1 ^ operand2;
            ALU_OP_SRL: result <= operand1 >> operand2[4:0];
            ALU_OP_SRA: result <= $signed(operand1) >>> operand2[4:0];
            ALU_OP_OR: result <= operand1 | operand2;
            ALU_OP_AND: result <= operand1 & operand2;
            // no operation holds the last result
            default: result <= result;
        endcase
    end

endmodule

// File: hw/branch_compare.sv
`timescale 1ns/1ps

module branch_compare (
    input core_pkg::word_t v1,
    input core_pkg::word_t v2,
    input logic [2:0] funct3,
    output logic taken
);

    always_comb begin
        case (funct3)
            3'b000: taken = (v1 == v2);
            3'b001: taken = (v1 != v2);
            3'b100: taken = ($signed(v1) < $signed(v2));
            3'b101: taken = ($signed(v1) >= $signed(v2));
            3'b110: taken = (v1 < v2);
            3'b111: taken = (v1 >= v2);
            // 010 and 011 are not branch codes
            default: taken = 1'b0;
        endcase
    end

endmodule

// File: hw/operand_select.sv
`timescale 1ns/1ps

module operand_select (
    input core_pkg::word_t pc,
    input core_pkg::word_t rs1_value,
    input core_pkg::word_t rs2_value,
    input logic is_branch,
    input logic is_jal,
    input logic is_jalr,
    input logic is_lui,
    input logic is_auipc,
    input logic is_load,
    input logic is_store,
    input logic is_alu_imm,
    input logic is_alu_reg,
    input logic [2:0] funct3,
    input logic sub_not_add,
    input logic shift_is_arith,
    input logic [4:0] shamt,
    input core_pkg::word_t imm_i,
    input core_pkg::word_t imm_s,
    input core_pkg::word_t imm_b,
    input core_pkg::word_t imm_u,
    input core_pkg::word_t imm_j,
    output core_pkg::word_t operand1,
    output core_pkg::word_t operand2,
    output core_pkg::alu_op_t operator
);
    import core_pkg::*;

    logic is_shift;

    assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

    always_comb begin
        if (is_jal || is_branch || is_auipc) begin
            operand1 = pc;
        end else if (is_lui) begin
            operand1 = '0;
        end else begin
            operand1 = rs1_value;
        end
    end

    always_comb begin
        if (is_alu_imm) begin
            operand2 = is_shift ? {27'd0, shamt} : imm_i;
        end else if (is_alu_reg) begin
            operand2 = is_shift ? {27'd0, rs2_value[4:0]} : rs2_value;
        end else if (is_load || is_jalr) begin
            operand2 = imm_i;
        end else if (is_store) begin
            operand2 = imm_s;
        end else if (is_branch) begin
            operand2 = imm_b;
        end else if (is_jal) begin
            operand2 = imm_j;
        end else if (is_lui || is_auipc) begin
            operand2 = imm_u;
        end else begin
            operand2 = '0;
        end
    end

    always_comb begin
        if (is_alu_imm || is_alu_reg) begin
            case (funct3)
                // addi has no subtract form
                3'b000: operator = (is_alu_reg && sub_not_add) ? ALU_OP_SUB : ALU_OP_ADD;
                3'b001: operator = ALU_OP_SLL;
                3'b010: operator = ALU_OP_SLT;
                3'b011: operator = ALU_OP_SLTU;
                3'b100: operator = ALU_OP_XOR;
                3'b101: operator = shift_is_arith ? ALU_OP_SRA : ALU_OP_SRL;
                3'b110: operator = ALU_OP_OR;
                default: operator = ALU_OP_AND;
            endcase
        end else if (is_branch || is_jal || is_jalr || is_lui || is_auipc
                || is_load || is_store) begin
            operator = ALU_OP_ADD;
        end else begin
            operator = ALU_OP_NONE;
        end
    end

endmodule

// File: hw/register_file.sv
`timescale 1ns/1ps

module register_file (
    input logic clock,
    input logic write,
    input core_pkg::reg_addr_t write_address,
    input core_pkg::word_t write_data,
    input core_pkg::reg_addr_t read1_address,
    input core_pkg::reg_addr_t read2_address,
    output core_pkg::word_t read1_data,
    output core_pkg::word_t read2_data
);
    import core_pkg::*;

    word_t regs [32];

    always_ff @(posedge clock) begin
        if (write && (write_address != '0)) begin
            regs[write_address] <= write_data;
        end
    end

    // x0 is hardwired to zero
    assign read1_data = (read1_address == '0) ? '0 : regs[read1_address];
    assign read2_data = (read2_address == '0) ? '0 : regs[read2_address];

    // the sequencer filters out rd 0 before retiring
    no_x0_write: assert property (@(posedge clock) write |-> (write_address != '0));

endmodule

// File: hw/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
    input core_pkg::word_t inst,
    output logic is_branch,
    output logic is_jal,
    output logic is_jalr,
    output logic is_lui,
    output logic is_auipc,
    output logic is_load,
    output logic is_store,
    output logic is_alu_imm,
    output logic is_alu_reg,
    output logic is_ebreak,
    output logic shift_is_arith,
    output logic sub_not_add,
    output core_pkg::reg_addr_t rs1,
    output core_pkg::reg_addr_t rs2,
    output core_pkg::reg_addr_t rd,
    output logic [2:0] funct3,
    output logic [4:0] shamt,
    output core_pkg::word_t imm_i,
    output core_pkg::word_t imm_s,
    output core_pkg::word_t imm_b,
    output core_pkg::word_t imm_u,
    output core_pkg::word_t imm_j
);
    import core_pkg::*;

    logic [6:0] opcode;

    assign opcode = inst[6:0];

    assign is_load = (opcode == OPC_LOAD);
    assign is_store = (opcode == OPC_STORE);
    assign is_branch = (opcode == OPC_BRANCH);
    assign is_jal = (opcode == OPC_JAL);
    assign is_jalr = (opcode == OPC_JALR);
    assign is_lui = (opcode == OPC_LUI);
    assign is_auipc = (opcode == OPC_AUIPC);
    assign is_alu_imm = (opcode == OPC_ALU_IMM);
    assign is_alu_reg = (opcode == OPC_ALU_REG);
    // ebreak is the system opcode with funct3 0 and immediate 1
    assign is_ebreak = (opcode == OPC_SYSTEM) && (funct3 == 3'b000) && (inst[31:20] == 12'd1);

    // bit 30 picks sra over srl and sub over add
    assign shift_is_arith = inst[30];
    assign sub_not_add = inst[30];

    assign rd = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];
    assign shamt = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'd0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

endmodule

// File: hw/core_sequencer.sv
`timescale 1ns/1ps

module core_sequencer (
    input logic clock,
    input logic reset_n,
    input logic run,
    output logic halted,
    output core_pkg::addr_t inst_ram_address,
    input core_pkg::word_t inst_ram_read_result,
    output core_pkg::addr_t data_ram_address,
    output core_pkg::word_t data_ram_write_data,
    output logic data_ram_write,
    input core_pkg::word_t data_ram_read_result,
    output core_pkg::word_t inst,
    input logic is_branch,
    input logic is_jal,
    input logic is_jalr,
    input logic is_lui,
    input logic is_auipc,
    input logic is_load,
    input logic is_store,
    input logic is_alu_imm,
    input logic is_alu_reg,
    input logic is_ebreak,
    input core_pkg::reg_addr_t rd,
    input core_pkg::word_t rs2_value,
    input core_pkg::word_t alu_result,
    input logic branch_taken,
    output core_pkg::word_t pc,
    output logic rd_write,
    output core_pkg::reg_addr_t rd_address,
    output core_pkg::word_t rd_value
);
    import core_pkg::*;

    seq_state_t state;
    logic branch_taken_q;
    logic writes_rd;
    logic is_jump;

    assign is_jump = is_jal || is_jalr;
    assign writes_rd = is_alu_imm || is_alu_reg || is_lui || is_auipc || is_jump || is_load;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state <= ST_INIT;
            pc <= '0;
            halted <= 1'b0;
            data_ram_write <= 1'b0;
            rd_write <= 1'b0;
            inst_ram_address <= '0;
        end else if (run) begin
            case (state)
                ST_INIT: state <= ST_FETCH;
                ST_FETCH: begin
                    // the retired write lands on this edge
                    rd_write <= 1'b0;
                    inst_ram_address <= pc[ADDR_BITS-1:0];
                    state <= ST_FETCH_WAIT;
                end
                ST_FETCH_WAIT: state <= ST_DECODE;
                ST_DECODE: begin
                    inst <= inst_ram_read_result;
                    state <= ST_READ_REGS;
                end
                ST_READ_REGS: begin
                    halted <= is_ebreak;
                    state <= ST_EXECUTE;
                end
                ST_EXECUTE: begin
                    branch_taken_q <= branch_taken;
                    if (halted) begin
                        state <= ST_HALTED;
                    end else if (is_load) begin
                        state <= ST_LOAD;
                    end else if (is_store) begin
                        state <= ST_STORE;
                    end else begin
                        state <= ST_RETIRE;
                    end
                end
                ST_LOAD: begin
                    data_ram_address <= alu_result[ADDR_BITS-1:0];
                    state <= ST_LOAD_WAIT;
                end
                ST_LOAD_WAIT: state <= ST_RETIRE;
                ST_STORE: begin
                    data_ram_address <= alu_result[ADDR_BITS-1:0];
                    data_ram_write_data <= rs2_value;
                    data_ram_write <= 1'b1;
                    state <= ST_RETIRE;
                end
                ST_RETIRE: begin
                    data_ram_write <= 1'b0;
                    rd_write <= writes_rd && (rd != '0);
                    rd_address <= rd;
                    if (is_jump) begin
                        rd_value <= pc + INST_BYTES;
                    end else if (is_load) begin
                        rd_value <= data_ram_read_result;
                    end else begin
                        rd_value <= alu_result;
                    end
                    // jalr targets may be odd, so bit 0 is dropped
                    if (is_jump) begin
                        pc <= {alu_result[WORD_BITS-1:1], 1'b0};
                    end else if (is_branch && branch_taken_q) begin
                        pc <= alu_result;
                    end else begin
                        pc <= pc + INST_BYTES;
                    end
                    state <= ST_FETCH;
                end
                ST_HALTED: state <= ST_HALTED;
                default: state <= ST_INIT;
            endcase
        end
    end

    // a store strobe lasts one running cycle
    single_store_pulse: assert property (@(posedge clock) disable iff (!reset_n)
        data_ram_write && run |=> !data_ram_write);

    halt_is_sticky: assert property (@(posedge clock) disable iff (!reset_n)
        halted |=> halted);

endmodule

// File: hw/shader_core.sv
`timescale 1ns/1ps

module shader_core (
    input logic clock,
    input logic reset_n,
    input logic run,
    output logic halted,
    output core_pkg::addr_t inst_ram_address,
    input core_pkg::word_t inst_ram_read_result,
    output core_pkg::addr_t data_ram_address,
    output core_pkg::word_t data_ram_write_data,
    output logic data_ram_write,
    input core_pkg::word_t data_ram_read_result
);
    import core_pkg::*;

    word_t inst;
    logic is_branch, is_jal, is_jalr, is_lui, is_auipc;
    logic is_load, is_store, is_alu_imm, is_alu_reg, is_ebreak;
    logic shift_is_arith, sub_not_add;
    reg_addr_t rs1, rs2, rd;
    logic [2:0] funct3;
    logic [4:0] shamt;
    word_t imm_i, imm_s, imm_b, imm_u, imm_j;

    word_t rs1_value, rs2_value;
    word_t operand1, operand2, alu_result;
    alu_op_t operator;
    logic branch_taken;

    word_t pc;
    logic rd_write;
    reg_addr_t rd_address;
    word_t rd_value;

    core_sequencer sequencer (.*);

    rv_decode decoder (.*);

    register_file registers (
        .clock(clock),
        .write(rd_write),
        .write_address(rd_address),
        .write_data(rd_value),
        .read1_address(rs1),
        .read2_address(rs2),
        .read1_data(rs1_value),
        .read2_data(rs2_value)
    );

    operand_select operands (.*);

    alu alu_unit (
        .clock(clock),
        .operand1(operand1),
        .operand2(operand2),
        .operator(operator),
        .result(alu_result)
    );

    branch_compare comparator (
        .v1(rs1_value),
        .v2(rs2_value),
        .funct3(funct3),
        .taken(branch_taken)
    );

endmodule

// File: test/tb_memory.sv
`timescale 1ns/1ps

module tb_memory (
    input logic clock,
    input core_pkg::addr_t inst_ram_address,
    output core_pkg::word_t inst_ram_read_result,
    input core_pkg::addr_t data_ram_address,
    input core_pkg::word_t data_ram_write_data,
    input logic data_ram_write,
    output core_pkg::word_t data_ram_read_result
);
    import core_pkg::*;

    // byte addresses, one word per entry
    word_t inst_mem [1024];
    word_t data_mem [1024];

    initial begin
        for (int i = 0; i < 1024; i++) begin
            data_mem[i] = 32'hdead_0000 ^ (i * 4);
        end
    end

    always @(posedge clock) begin
        inst_ram_read_result <= inst_mem[inst_ram_address[11:2]];
        data_ram_read_result <= data_mem[data_ram_address[11:2]];
        if (data_ram_write) begin
            data_mem[data_ram_address[11:2]] <= data_ram_write_data;
        end
    end

endmodule

// File: test/tb_shader_core.sv
`timescale 1ns/1ps

module tb_shader_core;
    import core_pkg::*;

    logic clock, reset_n, run, halted, data_ram_write;
    addr_t inst_ram_address, data_ram_address;
    word_t inst_ram_read_result, data_ram_read_result, data_ram_write_data;

    int seed = 32'h8892;
    int n_inst, slot, seen, cycles, cycle_limit, stable_addr;
    int test_end [5];
    int test_errors [5];
    string test_names [5] = '{"reset_state", "alu_ops", "load_x0_upper",
                              "branch_jump", "freeze_halt"};
    addr_t exp_addr [$];
    word_t exp_data [$];
    int exp_test [$];
    int f3_of [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
    // beq, bne, blt, bge, bltu, bgeu
    int branch_f3 [6] = '{0, 1, 4, 5, 6, 7};

    shader_core dut (.*);

    tb_memory mem (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic word_t alu_expect(int k, word_t a, word_t b);
        case (k)
            0: return a + b;
            1: return a - b;
            2: return a << b[4:0];
            3: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            4: return (a < b) ? 32'd1 : 32'd0;
            5: return a ^ b;
            6: return a >> b[4:0];
            7: return word_t'($signed(a) >>> b[4:0]);
            8: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_expect(int kind, word_t x, word_t y);
        case (kind)
            0: return x == y;
            1: return x != y;
            2: return $signed(x) < $signed(y);
            3: return $signed(x) >= $signed(y);
            4: return x < y;
            default: return x >= y;
        endcase
    endfunction

    function automatic word_t encode_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
            reg_addr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t encode_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
            logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    task automatic emit(word_t w);
        mem.inst_mem[n_inst] = w;
        n_inst++;
    endtask

    // lui/addi pair, the upper part rounded for the sign of the low 12 bits
    task automatic load_const(reg_addr_t rd, word_t v);
        word_t hi;
        hi = v + 32'h800;
        emit({hi[31:12], rd, OPC_LUI});
        emit(encode_i(v[11:0], rd, 3'd0, rd, OPC_ALU_IMM));
    endtask

    // sw rs to the next result slot; skipped stores expect nothing
    task automatic store_slot(reg_addr_t rs, word_t value, int test, logic expected);
        logic [11:0] addr;
        addr = 12'h200 + 12'(slot * 4);
        emit({addr[11:5], rs, 5'd0, 3'd2, addr[4:0], OPC_STORE});
        if (expected) begin
            exp_addr.push_back(addr_t'(addr));
            exp_data.push_back(value);
            exp_test.push_back(test);
        end
        slot++;
    endtask

    task automatic build_program();
        word_t a, b, bval, r, p;
        logic [11:0] imm;
        logic [19:0] u;
        logic taken;
        for (int i = 0; i < 1024; i++) begin
            mem.inst_mem[i] = 32'h0010_0073;
        end
        a = $random(seed);
        b = $random(seed);
        load_const(5'd1, a);
        load_const(5'd2, b);
        for (int k = 0; k < 10; k++) begin
            emit({(k == 1 || k == 7) ? 7'h20 : 7'h00, 5'd2, 5'd1, 3'(f3_of[k]), 5'd3,
                OPC_ALU_REG});
            store_slot(5'd3, alu_expect(k, a, b), 1, 1'b1);
        end
        // no subtract immediate form
        for (int k = 0; k < 10; k++) begin
            if (k != 1) begin
                imm = 12'($random(seed));
                if (k == 2 || k == 6 || k == 7) begin
                    imm = {(k == 7) ? 7'h20 : 7'h00, imm[4:0]};
                    bval = {27'd0, imm[4:0]};
                end else begin
                    bval = {{20{imm[11]}}, imm};
                end
                emit(encode_i(imm, 5'd1, 3'(f3_of[k]), 5'd3, OPC_ALU_IMM));
                store_slot(5'd3, alu_expect(k, a, bval), 1, 1'b1);
            end
        end
        test_end[1] = exp_addr.size();
        r = exp_data[0];
        emit(encode_i(12'h200, 5'd0, 3'd2, 5'd4, OPC_LOAD));
        emit(encode_i(12'd1, 5'd4, 3'd0, 5'd4, OPC_ALU_IMM));
        store_slot(5'd4, r + 1, 2, 1'b1);
        emit(encode_i(12'h123, 5'd0, 3'd0, 5'd0, OPC_ALU_IMM));
        store_slot(5'd0, 32'd0, 2, 1'b1);
        u = 20'($random(seed));
        emit({u, 5'd5, OPC_LUI});
        store_slot(5'd5, {u, 12'd0}, 2, 1'b1);
        u = 20'($random(seed));
        p = n_inst * 4;
        emit({u, 5'd6, OPC_AUIPC});
        store_slot(5'd6, {u, 12'd0} + p, 2, 1'b1);
        test_end[2] = exp_addr.size();
        emit(encode_i(12'h5a5, 5'd0, 3'd0, 5'd7, OPC_ALU_IMM));
        for (int kind = 0; kind < 6; kind++) begin
            for (int pass = 0; pass < 2; pass++) begin
                // eq/ne need equal operands once, the compares need swapped ones
                if (pass == 0) begin
                    taken = branch_expect(kind, a, b);
                    emit(encode_b(13'd8, 5'd2, 5'd1, 3'(branch_f3[kind])));
                end else if (kind < 2) begin
                    taken = branch_expect(kind, a, a);
                    emit(encode_b(13'd8, 5'd1, 5'd1, 3'(branch_f3[kind])));
                end else begin
                    taken = branch_expect(kind, b, a);
                    emit(encode_b(13'd8, 5'd1, 5'd2, 3'(branch_f3[kind])));
                end
                store_slot(5'd7, 32'h5a5, 3, !taken);
                store_slot(5'd7, 32'h5a5, 3, 1'b1);
            end
        end
        p = n_inst * 4;
        emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd9, OPC_JAL});
        store_slot(5'd7, 32'h5a5, 3, 1'b0);
        store_slot(5'd9, p + 4, 3, 1'b1);
        // odd jalr target, bit 0 dropped lands on the link store
        p = n_inst * 4;
        emit({20'd0, 5'd11, OPC_AUIPC});
        emit(encode_i(12'd13, 5'd11, 3'd0, 5'd10, OPC_JALR));
        store_slot(5'd7, 32'h5a5, 3, 1'b0);
        store_slot(5'd10, p + 8, 3, 1'b1);
        test_end[3] = exp_addr.size();
        emit(32'h0010_0073);
        store_slot(5'd7, 32'h5a5, 4, 1'b0);
        test_end[4] = exp_addr.size();
    endtask

    // one store per cycle with the strobe high
    always @(negedge clock) begin
        int t;
        if (data_ram_write) begin
            if (seen < exp_addr.size()) begin
                t = exp_test[seen];
                assert (data_ram_address == exp_addr[seen]) else begin
                    $display("error %s: store %0d address expected %h actual %h",
                        test_names[t], seen, exp_addr[seen], data_ram_address);
                    test_errors[t]++;
                end
                assert (data_ram_write_data == exp_data[seen]) else begin
                    $display("error %s: store %0d data expected %h actual %h",
                        test_names[t], seen, exp_data[seen], data_ram_write_data);
                    test_errors[t]++;
                end
            end else begin
                $display("unexpected store to address %h after all expected stores",
                    data_ram_address);
                test_errors[4]++;
            end
            seen++;
        end
    end

    initial begin
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
        end while (cycles < cycle_limit);
        $display("timeout after %0d cycles, core did not finish", cycles);
        $display("TB FAILED");
        $finish;
    end

    task automatic wait_stores(int n);
        while (seen < n) @(negedge clock);
    endtask

    task automatic report(int t);
        $display("test %-14s %s, %0d errors", test_names[t],
            (test_errors[t] == 0) ? "ok" : "failed", test_errors[t]);
    endtask

    initial begin
        int failed;
        reset_n = 1'b0;
        run = 1'b0;
        seen = 0;
        slot = 0;
        n_inst = 0;
        build_program();
        cycle_limit = n_inst * 8 + 120;
        for (int i = 0; i < 7; i++) begin
            @(negedge clock);
            assert (!halted && !data_ram_write && inst_ram_address == '0) else begin
                $display("core left its reset state before run was raised");
                test_errors[0]++;
            end
            if (i == 2) begin
                @(posedge clock);
                #2 reset_n = 1'b1;
            end
        end
        report(0);
        @(posedge clock);
        #2 run = 1'b1;
        wait_stores(test_end[1]);
        report(1);
        // freeze where no store strobe is pending
        do begin
            @(posedge clock);
            #2;
        end while (data_ram_write);
        run = 1'b0;
        stable_addr = inst_ram_address;
        repeat (20) begin
            @(negedge clock);
            assert (!data_ram_write && inst_ram_address == addr_t'(stable_addr)) else begin
                $display("core moved while run was low");
                test_errors[4]++;
            end
        end
        @(posedge clock);
        #2 run = 1'b1;
        wait_stores(test_end[2]);
        report(2);
        wait_stores(test_end[3]);
        report(3);
        while (!halted) @(negedge clock);
        repeat (20) begin
            @(negedge clock);
            assert (halted && !data_ram_write) else begin
                $display("core did not stay halted after ebreak");
                test_errors[4]++;
            end
        end
        assert (seen == test_end[4]) else begin
            $display("error freeze_halt: store count expected %0d actual %0d",
                test_end[4], seen);
            test_errors[4]++;
        end
        report(4);
        failed = 0;
        foreach (test_errors[t]) failed += (test_errors[t] != 0) ? 1 : 0;
        $display("tests run 5, failed %0d, stores seen %0d", failed, seen);
        if (failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
hw/core_pkg.sv
hw/alu.sv
hw/branch_compare.sv
hw/operand_select.sv
hw/register_file.sv
hw/rv_decode.sv
hw/core_sequencer.sv
hw/shader_core.sv
test/tb_memory.sv
test/tb_shader_core.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_shader_core -f list.f -o sim_shader_core
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_shader_core)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TB PASSED$"; then
    exit 0
fi
exit 1
